//--- design/privPkg.sv
// Package with the widths, reset values, enums and packed structs of the privileged unit
package privPkg;

  ////////////////////////////////////////////////////////////
  // Widths and reset values
  ////////////////////////////////////////////////////////////

  localparam int xlenW = 32;
  // Trap vector after reset, direct mode only
  localparam logic [xlenW-1:0] mtvecReset = 32'h0000_0100;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Privilege levels use the same encoding as the MPP field
  typedef enum logic [1:0] {modeU = 2'd0, modeS = 2'd1, modeM = 2'd3} privModeT;

  // Only the CSRs below exist, every other address is illegal
  typedef enum logic [11:0] {
    csrSstatus  = 12'h100, csrStvec  = 12'h105, csrSepc     = 12'h141,
    csrScause   = 12'h142, csrMstatus = 12'h300, csrMedeleg = 12'h302,
    csrMtvec    = 12'h305, csrMscratch = 12'h340, csrMepc   = 12'h341,
    csrMcause   = 12'h342
  } csrAddrT;

  // Decoded operation of the retiring instruction
  typedef enum logic [3:0] {
    opNone = 4'd0, opCsrRw = 4'd1, opCsrRs = 4'd2, opCsrRc = 4'd3, opEcall = 4'd4,
    opEbreak = 4'd5, opMret = 4'd6, opSret = 4'd7, opWfi = 4'd8, opIllegal = 4'd9
  } sysOpT;

  // Exception codes as written into mcause and scause
  typedef enum logic [3:0] {
    causeInstrMisaligned = 4'd0, causeInstrAccess = 4'd1, causeIllegal = 4'd2,
    causeBreakpoint = 4'd3, causeLoadAccess = 4'd5, causeStoreAccess = 4'd7,
    causeEcallU = 4'd8, causeEcallS = 4'd9, causeEcallM = 4'd11
  } causeT;

  ////////////////////////////////////////////////////////////
  // Bundles between the blocks
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic instrAccess;
    logic loadAccess;
    logic storeAccess;
  } faultsT;

  // One retiring instruction with its operand and fault flags
  typedef struct packed {
    logic [31:0]      instr;
    logic [xlenW-1:0] pc;
    logic [xlenW-1:0] srcA;
    faultsT           faults;
  } privReqT;

  typedef struct packed {
    sysOpT            op;
    logic [11:0]      csrAddr;
    logic [xlenW-1:0] operand;
    logic             csrWrite;
    logic             illegal;
  } decodeT;

  typedef struct packed {
    logic             take;
    logic             toS;
    causeT            cause;
    logic [xlenW-1:0] nextPc;
  } trapT;

  typedef struct packed {
    logic             trap;
    logic             ret;
    logic [xlenW-1:0] nextPc;
    logic [xlenW-1:0] csrReadVal;
    causeT            cause;
    privModeT         mode;
  } privRspT;

endpackage

//--- design/privDecode.sv
// System instruction decoder with CSR operand selection and privilege legality checks
`timescale 1ns/100ps

module privDecode
  import privPkg::*;
(
  input  privReqT  req,
  input  privModeT mode,
  input  logic     tsr,
  output decodeT   dec
);

  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic        isSystem;
  logic        csrKnown;
  logic        csrBad;
  logic [11:0] addr;

  assign funct3   = req.instr[14:12];
  assign rs1      = req.instr[19:15];
  assign addr     = req.instr[31:20];
  assign isSystem = req.instr[6:0] == 7'b1110011;

  // Classify the word, funct3 zero carries the fixed privileged encodings
  always_comb begin
    dec.op = opNone;
    if (isSystem) begin
      case (funct3)
        3'd1, 3'd5: dec.op = opCsrRw;
        3'd2, 3'd6: dec.op = opCsrRs;
        3'd3, 3'd7: dec.op = opCsrRc;
        3'd0: begin
          // rd and rs1 must be zero for these encodings
          dec.op = opIllegal;
          if (req.instr[19:7] == 13'd0) begin
            case (addr)
              12'h000: dec.op = opEcall;
              12'h001: dec.op = opEbreak;
              12'h302: dec.op = opMret;
              12'h102: dec.op = opSret;
              12'h105: dec.op = opWfi;
              default: dec.op = opIllegal;
            endcase
          end
        end
        default: dec.op = opIllegal;
      endcase
    end
  end

  // Immediate forms take the zero-extended rs1 field as operand
  assign dec.csrAddr  = addr;
  assign dec.operand  = funct3[2] ? {{(xlenW-5){1'b0}}, rs1} : req.srcA;
  // Set and clear with a zero source only read the CSR
  assign dec.csrWrite = (dec.op == opCsrRw) || (rs1 != 5'd0);

  always_comb begin
    case (addr)
      csrSstatus, csrStvec, csrSepc, csrScause, csrMstatus, csrMedeleg,
      csrMtvec, csrMscratch, csrMepc, csrMcause: csrKnown = 1'b1;
      default: csrKnown = 1'b0;
    endcase
  end

  // Address bits 9 to 8 give the lowest mode allowed to touch the CSR
  assign csrBad = !csrKnown || (addr[9:8] > mode);

  assign dec.illegal = (dec.op == opIllegal)
                    || ((dec.op inside {opCsrRw, opCsrRs, opCsrRc}) && csrBad)
                    || (dec.op == opMret && mode != modeM)
                    || (dec.op == opSret && (mode == modeU || (mode == modeS && tsr)))
                    || (dec.op == opWfi && mode == modeU);

endmodule

//--- design/trapUnit.sv
// Exception priority, cause selection, delegation and redirect PC for traps and returns
`timescale 1ns/100ps

module trapUnit
  import privPkg::*;
(
  input  decodeT           dec,
  input  logic [xlenW-1:0] pc,
  input  faultsT           faults,
  input  privModeT         mode,
  input  logic [xlenW-1:0] medeleg,
  input  logic [xlenW-1:0] mtvec,
  input  logic [xlenW-1:0] stvec,
  input  logic [xlenW-1:0] mepc,
  input  logic [xlenW-1:0] sepc,
  output trapT             trap
);

  logic  misaligned;
  logic  retSel;
  causeT ecallCause;

  assign misaligned = pc[1:0] != 2'b00;

  // Ecall reports the mode it was executed from
  always_comb begin
    case (mode)
      modeU:   ecallCause = causeEcallU;
      modeS:   ecallCause = causeEcallS;
      default: ecallCause = causeEcallM;
    endcase
  end

  // Fixed priority, the first matching condition wins
  always_comb begin
    trap.take  = 1'b1;
    trap.cause = causeInstrMisaligned;
    if (misaligned)                trap.cause = causeInstrMisaligned;
    else if (faults.instrAccess)   trap.cause = causeInstrAccess;
    else if (dec.illegal)          trap.cause = causeIllegal;
    else if (dec.op == opEbreak)   trap.cause = causeBreakpoint;
    else if (dec.op == opEcall)    trap.cause = ecallCause;
    else if (faults.loadAccess)    trap.cause = causeLoadAccess;
    else if (faults.storeAccess)   trap.cause = causeStoreAccess;
    else                           trap.take  = 1'b0;
  end

  // Delegation never lowers a trap taken from M
  assign trap.toS = trap.take && medeleg[trap.cause] && (mode != modeM);

  // A return only redirects when nothing traps
  assign retSel = (dec.op inside {opMret, opSret}) && !trap.take;

  always_comb begin
    if (trap.take) begin
      trap.nextPc = trap.toS ? stvec : mtvec;
    end else if (retSel) begin
      trap.nextPc = (dec.op == opMret) ? mepc : sepc;
    end else begin
      trap.nextPc = '0;
    end
  end

  // A return that redirects must be allowed in the current mode, mret from M and sret above U
  retLegal: assert final (!(retSel && ((dec.op == opMret) ? (mode != modeM) : (mode == modeU))))
    else $error("return redirected from a mode that may not execute it");

endmodule

//--- design/csrFile.sv
// Machine and supervisor CSR registers, read multiplexer, write data and trap state updates
`timescale 1ns/100ps

module csrFile
  import privPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic             csrWe,
  input  csrAddrT          csrAddr,
  input  sysOpT            op,
  input  logic [xlenW-1:0] operand,
  input  logic             trapEn,
  input  trapT             trap,
  input  logic [xlenW-1:0] pc,
  input  privModeT         mode,
  input  logic             mretEn,
  input  logic             sretEn,
  output logic [xlenW-1:0] rdata,
  output logic [xlenW-1:0] medeleg,
  output logic [xlenW-1:0] mtvec,
  output logic [xlenW-1:0] stvec,
  output logic [xlenW-1:0] mepc,
  output logic [xlenW-1:0] sepc,
  output privModeT         mpp,
  output logic             spp,
  output logic             tsr
);

  logic [xlenW-1:0] mscratch;
  logic [3:0]       mcause;
  logic [3:0]       scause;
  logic [xlenW-1:0] wdata;
  privModeT         wrMpp;

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // The old value is returned, the write lands at the closing edge
  always_comb begin
    case (csrAddr)
      csrSstatus:  rdata = {23'd0, spp, 8'd0};
      csrMstatus:  rdata = {9'd0, tsr, 9'd0, mpp, 2'd0, spp, 8'd0};
      csrStvec:    rdata = stvec;
      csrSepc:     rdata = sepc;
      csrScause:   rdata = {28'd0, scause};
      csrMedeleg:  rdata = medeleg;
      csrMtvec:    rdata = mtvec;
      csrMscratch: rdata = mscratch;
      csrMepc:     rdata = mepc;
      csrMcause:   rdata = {28'd0, mcause};
      default:     rdata = '0;
    endcase
  end

  // Read-modify-write data for the three CSR flavours
  always_comb begin
    case (op)
      opCsrRs: wdata = rdata | operand;
      opCsrRc: wdata = rdata & ~operand;
      default: wdata = operand;
    endcase
  end

  // MPP value 2 is reserved and falls back to U
  assign wrMpp = (wdata[12:11] == 2'b10) ? modeU : privModeT'(wdata[12:11]);

  ////////////////////////////////////////////////////////////
  // Register updates
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tsr      <= 1'b0;
      mpp      <= modeU;
      spp      <= 1'b0;
      medeleg  <= '0;
      mtvec    <= mtvecReset;
      stvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      sepc     <= '0;
      mcause   <= '0;
      scause   <= '0;
    end else if (trapEn) begin
      // Exceptions save the PC and cause in the target mode's registers
      if (trap.toS) begin
        sepc   <= {pc[xlenW-1:2], 2'b00};
        scause <= trap.cause;
        spp    <= mode[0];
      end else begin
        mepc   <= {pc[xlenW-1:2], 2'b00};
        mcause <= trap.cause;
        mpp    <= mode;
      end
    end else if (mretEn) begin
      mpp <= modeU;
    end else if (sretEn) begin
      spp <= 1'b0;
    end else if (csrWe) begin
      case (csrAddr)
        csrSstatus: spp <= wdata[8];
        csrMstatus: begin
          tsr <= wdata[22];
          mpp <= wrMpp;
          spp <= wdata[8];
        end
        csrMedeleg:  medeleg  <= wdata;
        // Vector and return addresses are kept word aligned
        csrMtvec:    mtvec    <= {wdata[xlenW-1:2], 2'b00};
        csrStvec:    stvec    <= {wdata[xlenW-1:2], 2'b00};
        csrMepc:     mepc     <= {wdata[xlenW-1:2], 2'b00};
        csrSepc:     sepc     <= {wdata[xlenW-1:2], 2'b00};
        csrMscratch: mscratch <= wdata;
        csrMcause:   mcause   <= wdata[3:0];
        csrScause:   scause   <= wdata[3:0];
        default: ;
      endcase
    end
  end

  // A trapping request must never also write a CSR
  csrWeTrapExcl: assert property (@(posedge clk) disable iff (!arstN) !(csrWe && trapEn))
    else $error("csrWe and trapEn high in the same cycle");

endmodule

//--- design/privCtrl.sv
// Privilege mode register, per-request strobes and the registered response
`timescale 1ns/100ps

module privCtrl
  import privPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic             reqValid,
  input  decodeT           dec,
  input  trapT             trap,
  input  logic [xlenW-1:0] rdata,
  input  privModeT         mpp,
  input  logic             spp,
  output logic             csrWe,
  output logic             trapEn,
  output logic             mretEn,
  output logic             sretEn,
  output privModeT         mode,
  output privRspT          rsp,
  output logic             rspValid
);

  logic     csrOp;
  privModeT nextMode;

  assign csrOp = dec.op inside {opCsrRw, opCsrRs, opCsrRc};

  // Strobes only fire for a valid request, and a trap blocks all others
  assign trapEn = reqValid && trap.take;
  assign csrWe  = reqValid && csrOp && dec.csrWrite && !trap.take;
  assign mretEn = reqValid && (dec.op == opMret) && !trap.take;
  assign sretEn = reqValid && (dec.op == opSret) && !trap.take;

  always_comb begin
    if (trapEn)      nextMode = trap.toS ? modeS : modeM;
    else if (mretEn) nextMode = mpp;
    else if (sretEn) nextMode = privModeT'({1'b0, spp});
    else             nextMode = mode;
  end

  // Mode moves at the same edge as the CSR updates
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mode     <= modeM;
      rspValid <= 1'b0;
    end else begin
      mode     <= nextMode;
      rspValid <= reqValid;
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) begin
      rsp.trap       <= trap.take;
      rsp.ret        <= mretEn || sretEn;
      rsp.nextPc     <= trap.nextPc;
      rsp.csrReadVal <= (csrOp && !trap.take) ? rdata : '0;
      rsp.cause      <= trap.cause;
      rsp.mode       <= nextMode;
    end
  end

  modeNotReserved: assert property (@(posedge clk) disable iff (!arstN) mode != privModeT'(2'b10))
    else $error("mode holds reserved value 2");
  rspKnown: assert property (@(posedge clk) disable iff (!arstN)
    rspValid |-> !$isunknown(rsp)) else $error("response holds unknown bits");

endmodule

//--- design/privTop.sv
// Top level of the privileged unit wiring decode, trap unit, CSR file and control
`timescale 1ns/100ps

module privTop
  import privPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  privReqT  req,
  input  logic     reqValid,
  output privRspT  rsp,
  output logic     rspValid,
  output privModeT mode
);

  decodeT           dec;
  trapT             trap;
  logic [xlenW-1:0] rdata, medeleg, mtvec, stvec, mepc, sepc;
  privModeT         mpp;
  logic             spp, tsr;
  logic             csrWe, trapEn, mretEn, sretEn;

  privDecode uDecode (.req, .mode, .tsr, .dec);

  trapUnit uTrap (
    .dec, .pc(req.pc), .faults(req.faults), .mode,
    .medeleg, .mtvec, .stvec, .mepc, .sepc, .trap
  );

  csrFile uCsr (
    .clk, .arstN, .csrWe, .csrAddr(csrAddrT'(dec.csrAddr)), .op(dec.op),
    .operand(dec.operand), .trapEn, .trap, .pc(req.pc), .mode, .mretEn, .sretEn,
    .rdata, .medeleg, .mtvec, .stvec, .mepc, .sepc, .mpp, .spp, .tsr
  );

  privCtrl uCtrl (
    .clk, .arstN, .reqValid, .dec, .trap, .rdata, .mpp, .spp,
    .csrWe, .trapEn, .mretEn, .sretEn, .mode, .rsp, .rspValid
  );

endmodule

//--- tests/clkGen.sv
// Clock and reset generator for the testbench
`timescale 1ns/100ps

module clkGen (
  output logic clk,
  output logic arstN
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset is held for five rising edges and released away from the edge
  initial begin
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

//--- tests/privModel.svh
// Reference model state of the mode and CSRs, CSR access helpers and the per-request step task
`ifndef PRIV_MODEL_SVH
`define PRIV_MODEL_SVH

privModeT    modelMode;
privModeT    modelMpp;
logic        modelTsr;
logic        modelSpp;
logic [31:0] modelMedeleg, modelMtvec, modelStvec, modelMscratch, modelMepc, modelSepc;
logic [3:0]  modelMcause, modelScause;

task automatic modelReset();
  modelMode     = modeM;
  modelMpp      = modeU;
  modelTsr      = 1'b0;
  modelSpp      = 1'b0;
  modelMedeleg  = '0;
  modelMtvec    = mtvecReset;
  modelStvec    = '0;
  modelMscratch = '0;
  modelMepc     = '0;
  modelSepc     = '0;
  modelMcause   = '0;
  modelScause   = '0;
endtask

// Returns one when the address exists, val gets the architectural view
function automatic logic csrLookup(input logic [11:0] addr, output logic [31:0] val);
  csrLookup = 1'b1;
  val = '0;
  case (addr)
    csrSstatus:  val[8] = modelSpp;
    csrMstatus:  val = (32'(modelTsr) << 22) | (32'(modelMpp) << 11) | (32'(modelSpp) << 8);
    csrMedeleg:  val = modelMedeleg;
    csrMtvec:    val = modelMtvec;
    csrStvec:    val = modelStvec;
    csrMscratch: val = modelMscratch;
    csrMepc:     val = modelMepc;
    csrSepc:     val = modelSepc;
    csrMcause:   val = {28'd0, modelMcause};
    csrScause:   val = {28'd0, modelScause};
    default:     csrLookup = 1'b0;
  endcase
endfunction

task automatic csrStore(input logic [11:0] addr, input logic [31:0] val);
  case (addr)
    csrSstatus: modelSpp = val[8];
    csrMstatus: begin
      modelTsr = val[22];
      // The reserved MPP encoding reads back as U
      modelMpp = (val[12:11] == 2'b10) ? modeU : privModeT'(val[12:11]);
      modelSpp = val[8];
    end
    csrMedeleg:  modelMedeleg  = val;
    csrMtvec:    modelMtvec    = val & ~32'd3;
    csrStvec:    modelStvec    = val & ~32'd3;
    csrMscratch: modelMscratch = val;
    csrMepc:     modelMepc     = val & ~32'd3;
    csrSepc:     modelSepc     = val & ~32'd3;
    csrMcause:   modelMcause   = val[3:0];
    csrScause:   modelScause   = val[3:0];
    default: ;
  endcase
endtask

// Applies one request to the model and returns the response it expects
task automatic modelStep(input privReqT r, output privRspT exp);
  logic [2:0]  f3;
  logic [11:0] addr;
  logic        sys, priv, isCsr, known, bad, take, toS;
  logic [31:0] oldVal, opnd;
  logic [3:0]  cause;
  f3    = r.instr[14:12];
  addr  = r.instr[31:20];
  sys   = r.instr[6:0] == 7'h73;
  isCsr = sys && f3 != 3'd0 && f3 != 3'd4;
  priv  = sys && f3 == 3'd0 && r.instr[19:7] == 13'd0;
  known = csrLookup(addr, oldVal);
  bad   = sys && !isCsr && !(priv && addr inside {12'h000, 12'h001, 12'h102, 12'h302, 12'h105});
  // Privilege rules on top of the encoding check
  if (isCsr && (!known || addr[9:8] > modelMode)) bad = 1'b1;
  if (priv && addr == 12'h302 && modelMode != modeM) bad = 1'b1;
  if (priv && addr == 12'h102 && (modelMode == modeU || (modelMode == modeS && modelTsr)))
    bad = 1'b1;
  if (priv && addr == 12'h105 && modelMode == modeU) bad = 1'b1;
  take = 1'b1;
  if (r.pc[1:0] != 2'b00) cause = 4'd0;
  else if (r.faults.instrAccess) cause = 4'd1;
  else if (bad) cause = 4'd2;
  else if (priv && addr == 12'h001) cause = 4'd3;
  else if (priv && addr == 12'h000) cause = 4'd8 + 4'(modelMode);
  else if (r.faults.loadAccess) cause = 4'd5;
  else if (r.faults.storeAccess) cause = 4'd7;
  else begin
    take  = 1'b0;
    cause = 4'd0;
  end
  toS  = take && modelMedeleg[cause] && modelMode != modeM;
  opnd = f3[2] ? {27'd0, r.instr[19:15]} : r.srcA;
  exp  = '0;
  exp.trap  = take;
  exp.cause = causeT'(cause);
  if (take) begin
    exp.nextPc = toS ? modelStvec : modelMtvec;
    if (toS) begin
      modelSepc   = {r.pc[31:2], 2'b00};
      modelScause = cause;
      modelSpp    = modelMode[0];
      modelMode   = modeS;
    end else begin
      modelMepc   = {r.pc[31:2], 2'b00};
      modelMcause = cause;
      modelMpp    = modelMode;
      modelMode   = modeM;
    end
  end else if (priv && addr == 12'h302) begin
    exp.ret    = 1'b1;
    exp.nextPc = modelMepc;
    modelMode  = modelMpp;
    modelMpp   = modeU;
  end else if (priv && addr == 12'h102) begin
    exp.ret    = 1'b1;
    exp.nextPc = modelSepc;
    modelMode  = modelSpp ? modeS : modeU;
    modelSpp   = 1'b0;
  end else if (isCsr) begin
    exp.csrReadVal = oldVal;
    if (f3[1:0] == 2'd1) csrStore(addr, opnd);
    else if (r.instr[19:15] != 5'd0)
      csrStore(addr, (f3[1:0] == 2'd2) ? (oldVal | opnd) : (oldVal & ~opnd));
  end
  exp.mode = modelMode;
endtask

`endif

//--- tests/privTb.sv
// Testbench top with directed and random tests of the privileged unit against the model
`timescale 1ns/100ps

module privTb
  import privPkg::*;
();

  localparam int directedReqs = 70;
  localparam int randomReqs   = 2000;
  localparam int cycleLimit   = 2 * (directedReqs + randomReqs) + 100;

  logic     clk, arstN;
  privReqT  req;
  logic     reqValid;
  privRspT  rsp;
  logic     rspValid;
  privModeT mode;
  privRspT  expRsp;
  logic     pending;
  int       errorCount, testFails, testCount, startErrors, cycleCount;

  `include "privModel.svh"

  clkGen uClk (.clk, .arstN);

  privTop DUT (.clk, .arstN, .req, .reqValid, .rsp, .rspValid, .mode);

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, want);
      errorCount++;
    end
  endtask

  // The response of the previous request is stable at the falling edge
  task automatic checkPending();
    if (pending) begin
      assert (rspValid === 1'b1) else begin
        $display("Response strobe missing at %0t ns", $time);
        errorCount++;
      end
      expectEq("trap", rsp.trap, expRsp.trap);
      expectEq("ret", rsp.ret, expRsp.ret);
      expectEq("csrReadVal", rsp.csrReadVal, expRsp.csrReadVal);
      expectEq("rsp mode", rsp.mode, expRsp.mode);
      expectEq("mode output", mode, expRsp.mode);
      if (expRsp.trap) expectEq("cause", rsp.cause, expRsp.cause);
      if (expRsp.trap || expRsp.ret) expectEq("nextPc", rsp.nextPc, expRsp.nextPc);
    end else begin
      assert (rspValid === 1'b0) else begin
        $display("Response strobe without a request at %0t ns", $time);
        errorCount++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic issue(input logic [31:0] instr, input logic [31:0] pc, input logic [31:0] srcA,
                       input faultsT faults);
    @(negedge clk);
    checkPending();
    req.instr  = instr;
    req.pc     = pc;
    req.srcA   = srcA;
    req.faults = faults;
    reqValid   = 1'b1;
    modelStep(req, expRsp);
    pending = 1'b1;
  endtask

  task automatic idle();
    @(negedge clk);
    checkPending();
    reqValid = 1'b0;
    req      = '0;
    pending  = 1'b0;
  endtask

  function automatic logic [31:0] csrWord(input logic [2:0] f3, input logic [11:0] addr,
                                          input logic [4:0] rs1);
    csrWord = {addr, rs1, f3, 5'd1, 7'h73};
  endfunction

  // f3 1, 2 and 3 are rw, rs and rc; 5 is the immediate rw form
  task automatic csrAccess(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1,
                           input logic [31:0] srcA);
    issue(csrWord(f3, addr, rs1), 32'h0000_1000, srcA, '0);
  endtask

  task automatic sysOp(input logic [11:0] f12, input logic [31:0] pc, input faultsT faults);
    issue({f12, 13'd0, 7'h73}, pc, 32'h0, faults);
  endtask

  function automatic logic [11:0] csrAt(input int idx);
    case (idx)
      0: csrAt = csrSstatus;
      1: csrAt = csrStvec;
      2: csrAt = csrSepc;
      3: csrAt = csrScause;
      4: csrAt = csrMstatus;
      5: csrAt = csrMedeleg;
      6: csrAt = csrMtvec;
      7: csrAt = csrMscratch;
      8: csrAt = csrMepc;
      default: csrAt = csrMcause;
    endcase
  endfunction

  // Weighted classes: CSR ops, privileged ops, odd SYSTEM words, plain instructions
  task automatic randomReq();
    int          cls;
    logic [2:0]  f3, fbits;
    logic [31:0] instr, pc;
    faultsT      flt;
    cls = $urandom_range(99);
    if (cls < 40) begin
      f3 = 3'($urandom_range(1, 6));
      if (f3 >= 3'd4) f3 = f3 + 3'd1;
      instr = csrWord(f3, ($urandom_range(9) < 8) ? csrAt($urandom_range(9)) : 12'($urandom),
                      5'($urandom));
    end else if (cls < 55) begin
      case ($urandom_range(4))
        0: instr = {12'h000, 13'd0, 7'h73};
        1: instr = {12'h001, 13'd0, 7'h73};
        2: instr = {12'h302, 13'd0, 7'h73};
        3: instr = {12'h102, 13'd0, 7'h73};
        default: instr = {12'h105, 13'd0, 7'h73};
      endcase
    end else if (cls < 63) begin
      instr = $urandom;
      instr[6:0]   = 7'h73;
      instr[14:12] = ($urandom_range(1) == 0) ? 3'd0 : 3'd4;
    end else begin
      instr = $urandom;
      instr[6:0] = 7'h13;
    end
    pc = $urandom;
    if ($urandom_range(19) != 0) pc[1:0] = 2'b00;
    fbits = ($urandom_range(7) == 0) ? 3'($urandom_range(7)) : 3'd0;
    flt = fbits;
    issue(instr, pc, $urandom, flt);
  endtask

  task automatic endTest(input string name);
    idle();
    testCount++;
    if (errorCount > startErrors) begin
      testFails++;
      $display("Test %-12s failed with %0d errors", name, errorCount - startErrors);
    end else begin
      $display("Test %-12s passed", name);
    end
    startErrors = errorCount;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h69c5));
    req         = '0;
    reqValid    = 1'b0;
    pending     = 1'b0;
    errorCount  = 0;
    testFails   = 0;
    testCount   = 0;
    startErrors = 0;
    modelReset();
    @(posedge arstN);
    @(negedge clk);
    expectEq("mode after reset", mode, modeM);
    for (int i = 0; i < 10; i++) csrAccess(3'd2, csrAt(i), 5'd0, 32'hffff_ffff);
    endTest("reset");

    // Read-modify-write, masks, then an illegal address and a U-mode access
    csrAccess(3'd1, csrMscratch, 5'd5, 32'hdead_beef);
    csrAccess(3'd2, csrMscratch, 5'd5, 32'h0000_00f0);
    csrAccess(3'd3, csrMscratch, 5'd5, 32'hffff_0000);
    csrAccess(3'd2, csrMscratch, 5'd0, 32'h0);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'hffff_ffff);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0000_1000);
    csrAccess(3'd1, csrSstatus, 5'd5, 32'h0);
    csrAccess(3'd2, csrMstatus, 5'd0, 32'h0);
    csrAccess(3'd5, csrMtvec, 5'h1f, 32'h0);
    csrAccess(3'd1, csrMtvec, 5'd5, 32'h0000_0203);
    csrAccess(3'd1, csrMcause, 5'd5, 32'hffff_ffff);
    csrAccess(3'd2, csrMcause, 5'd0, 32'h0);
    csrAccess(3'd1, 12'h7c0, 5'd5, 32'h1);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0);
    csrAccess(3'd1, csrMepc, 5'd5, 32'h0000_2003);
    sysOp(12'h302, 32'h0000_1004, '0);
    csrAccess(3'd2, csrSstatus, 5'd0, 32'h0);
    csrAccess(3'd2, csrMepc, 5'd0, 32'h0);
    endTest("csrAccess");

    // Priority between the PC, the fault flags and the instruction
    sysOp(12'h000, 32'h0000_3000, '0);
    sysOp(12'h001, 32'h0000_3004, '0);
    sysOp(12'h001, 32'h0000_3006, '0);
    sysOp(12'h000, 32'h0000_3008, 3'b100);
    issue(32'h0000_0013, 32'h0000_300c, 32'h0, 3'b011);
    issue(32'h0000_0013, 32'h0000_3010, 32'h0, 3'b001);
    issue(csrWord(3'd4, 12'h000, 5'd0), 32'h0000_3014, 32'h0, 3'b010);
    csrAccess(3'd2, csrMepc, 5'd0, 32'h0);
    csrAccess(3'd2, csrMcause, 5'd0, 32'h0);
    csrAccess(3'd2, csrMstatus, 5'd0, 32'h0);
    endTest("exceptions");

    // Breakpoint and both ecalls delegated, illegal stays in M
    csrAccess(3'd1, csrMedeleg, 5'd5, 32'h0000_0308);
    csrAccess(3'd1, csrStvec, 5'd5, 32'h0000_0400);
    sysOp(12'h001, 32'h0000_4000, '0);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0000_0800);
    csrAccess(3'd1, csrMepc, 5'd5, 32'h0000_5000);
    sysOp(12'h302, 32'h0000_4004, '0);
    sysOp(12'h000, 32'h0000_5000, '0);
    csrAccess(3'd2, csrSepc, 5'd0, 32'h0);
    csrAccess(3'd2, csrScause, 5'd0, 32'h0);
    csrAccess(3'd2, csrSstatus, 5'd0, 32'h0);
    csrAccess(3'd1, csrSstatus, 5'd5, 32'h0);
    sysOp(12'h102, 32'h0000_5004, '0);
    sysOp(12'h001, 32'h0000_6000, '0);
    csrAccess(3'd2, csrMstatus, 5'd0, 32'h0);
    endTest("delegation");

    // TSR, returns from the wrong mode, wfi in M and U
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0040_0800);
    csrAccess(3'd1, csrMepc, 5'd5, 32'h0000_7000);
    sysOp(12'h302, 32'h0000_7100, '0);
    sysOp(12'h102, 32'h0000_7000, '0);
    sysOp(12'h302, 32'h0000_7104, '0);
    sysOp(12'h302, 32'h0000_7000, '0);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0000_0900);
    sysOp(12'h302, 32'h0000_7108, '0);
    sysOp(12'h102, 32'h0000_7000, '0);
    csrAccess(3'd2, csrSstatus, 5'd0, 32'h0);
    sysOp(12'h302, 32'h0000_7000, '0);
    csrAccess(3'd1, csrMstatus, 5'd5, 32'h0);
    sysOp(12'h105, 32'h0000_710c, '0);
    sysOp(12'h302, 32'h0000_7110, '0);
    sysOp(12'h102, 32'h0000_8000, '0);
    sysOp(12'h302, 32'h0000_7114, '0);
    sysOp(12'h105, 32'h0000_8004, '0);
    csrAccess(3'd2, csrMstatus, 5'd0, 32'h0);
    endTest("returns");

    for (int i = 0; i < randomReqs; i++) randomReq();
    endTest("randomMix");

    $display("Summary: %0d tests, %0d failed, %0d errors", testCount, testFails, errorCount);
    if (errorCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog on the total number of clock cycles
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run stopped after %0d cycles", cycleCount);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+tests
design/privPkg.sv
design/privDecode.sv
design/trapUnit.sv
design/csrFile.sv
design/privCtrl.sv
design/privTop.sv
tests/clkGen.sv
tests/privTb.sv
